/* verilog/elem_types_pkg.sv */
`default_nettype none

package elem_types_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int LANE_W  = 8;
    localparam int ACC_W   = 32;
    localparam int MULT_W  = 32;
    localparam int SHIFT_W = 8;

    typedef logic signed [LANE_W-1:0]  lane_t;
    typedef logic signed [ACC_W-1:0]   acc_t;
    // Q31 fixed point
    typedef logic signed [MULT_W-1:0]  mult_t;
    // positive means left, negative means right
    typedef logic signed [SHIFT_W-1:0] shift_t;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } elem_op_e;

    // --------------------------------------------------
    // config sets, held constant while beats are in flight
    // --------------------------------------------------
    typedef struct packed {
        acc_t   input1_offset;
        acc_t   input2_offset;
        shift_t left_shift;
        mult_t  input1_multiplier;
        mult_t  input2_multiplier;
        shift_t input1_shift;
        shift_t input2_shift;
    } in_scale_cfg_t;

    typedef struct packed {
        acc_t input1_offset;
        acc_t input2_offset;
    } mul_in_cfg_t;

    typedef struct packed {
        mult_t  output_multiplier;
        shift_t output_shift;
        acc_t   output_offset;
        lane_t  act_min;
        lane_t  act_max;
    } out_cfg_t;

endpackage

`default_nettype wire

/* verilog/elem_arith_pkg.sv */
`default_nettype none

package elem_arith_pkg;
    import elem_types_pkg::*;

    localparam acc_t  ACC_MIN  = 32'sh8000_0000;
    localparam acc_t  ACC_MAX  = 32'sh7fff_ffff;
    localparam mult_t MULT_MIN = 32'sh8000_0000;

    // divide by 2**exponent, rounding half away from zero
    function automatic acc_t rounding_div_pot(acc_t x, int exponent);
        acc_t mask;
        acc_t remainder;
        acc_t threshold;
        mask      = acc_t'((64'sd1 <<< exponent) - 64'sd1);
        remainder = x & mask;
        threshold = (mask >>> 1) + ((x < 0) ? 1 : 0);
        return (x >>> exponent) + ((remainder > threshold) ? 1 : 0);
    endfunction

    // --------------------------------------------------
    // multiply by quantized multiplier
    // --------------------------------------------------
    function automatic acc_t mbqm(acc_t x, mult_t mult, shift_t shift);
        int                 left;
        int                 right;
        acc_t               xs;
        logic signed [63:0] prod;
        logic signed [63:0] nudge;
        logic signed [63:0] high;
        acc_t               doubled;
        left  = (shift > 0) ? int'(shift) : 0;
        right = (shift > 0) ? 0 : -int'(shift);
        xs    = x <<< left;
        // the only product that overflows the doubling high multiply
        if (xs == ACC_MIN && mult == MULT_MIN) begin
            doubled = ACC_MAX;
        end else begin
            prod  = 64'(xs) * 64'(mult);
            nudge = (prod >= 0) ? 64'sd1073741824 : 64'sd1 - 64'sd1073741824;
            // signed divide truncates toward zero
            high    = (prod + nudge) / 64'sd2147483648;
            doubled = acc_t'(high);
        end
        return rounding_div_pot(doubled, right);
    endfunction

    function automatic lane_t clamp_to_lane(acc_t v, lane_t lo, lane_t hi);
        if (v < acc_t'(lo)) begin
            return lo;
        end
        if (v > acc_t'(hi)) begin
            return hi;
        end
        return lane_t'(v);
    endfunction

endpackage

`default_nettype wire

/* verilog/elem_stream_if.sv */
`default_nettype none

// credit based lane vector link, rx never refuses a valid item
interface elem_stream_if #(
    parameter int LANES = 8
);
    import elem_types_pkg::*;

    logic     valid;
    elem_op_e op;
    // first operands in [0, LANES), second operands above
    acc_t     lanes [2*LANES];
    // one pulse returns one credit
    logic     credit;

    modport tx (output valid, output op, output lanes, input credit);
    modport rx (input valid, input op, input lanes, output credit);

endinterface

`default_nettype wire

/* verilog/operand_stage.sv */
`default_nettype none

module operand_stage #(
    parameter int LANES     = 8,
    parameter int BUF_DEPTH = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_valid_i,
    output logic                              in_ready_o,
    input  elem_types_pkg::elem_op_e          op_i,
    input  elem_types_pkg::lane_t [LANES-1:0] data1_i,
    input  elem_types_pkg::lane_t [LANES-1:0] data2_i,
    input  elem_types_pkg::in_scale_cfg_t     scale_cfg_i,
    input  elem_types_pkg::mul_in_cfg_t       mul_cfg_i,
    elem_stream_if.tx                         link
);
    import elem_types_pkg::*;
    import elem_arith_pkg::*;

    localparam int CRED_W = $clog2(BUF_DEPTH + 1);

    logic [CRED_W-1:0] credits;
    logic              accept;
    acc_t              sum_a [LANES];
    acc_t              sum_b [LANES];
    logic              s1_valid;
    elem_op_e          s1_op;
    acc_t              s1_a [LANES];
    acc_t              s1_b [LANES];

    // one credit per free buffer entry
    assign in_ready_o = (credits != '0);
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (!rst) begin
            credits <= CRED_W'(BUF_DEPTH);
        end else begin
            credits <= credits - CRED_W'(accept) + CRED_W'(link.credit);
        end
    end

    // --------------------------------------------------
    // stage one, offsets and the MUL product
    // --------------------------------------------------
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            if (op_i == OP_MUL) begin
                sum_a[l] = acc_t'(lane_t'(data1_i[l])) + mul_cfg_i.input1_offset;
                sum_b[l] = acc_t'(lane_t'(data2_i[l])) + mul_cfg_i.input2_offset;
            end else begin
                sum_a[l] = acc_t'(lane_t'(data1_i[l])) + scale_cfg_i.input1_offset;
                sum_b[l] = acc_t'(lane_t'(data2_i[l])) + scale_cfg_i.input2_offset;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        s1_op <= op_i;
        for (int l = 0; l < LANES; l++) begin
            s1_a[l] <= (op_i == OP_MUL) ? sum_a[l] * sum_b[l] : sum_a[l];
            s1_b[l] <= sum_b[l];
        end
    end

    // --------------------------------------------------
    // stage two, input scaling for ADD and SUB
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            link.valid <= 1'b0;
        end else begin
            link.valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        link.op <= s1_op;
        for (int l = 0; l < LANES; l++) begin
            if (s1_op == OP_MUL) begin
                link.lanes[l]       <= s1_a[l];
                link.lanes[LANES+l] <= '0;
            end else begin
                link.lanes[l]       <= mbqm(s1_a[l] <<< scale_cfg_i.left_shift,
                                            scale_cfg_i.input1_multiplier,
                                            scale_cfg_i.input1_shift);
                link.lanes[LANES+l] <= mbqm(s1_b[l] <<< scale_cfg_i.left_shift,
                                            scale_cfg_i.input2_multiplier,
                                            scale_cfg_i.input2_shift);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/result_buffer.sv */
`default_nettype none

module result_buffer #(
    parameter int LANES     = 8,
    parameter int BUF_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    elem_stream_if.rx wr,
    elem_stream_if.tx rd
);
    import elem_types_pkg::*;

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int OCC_W = $clog2(BUF_DEPTH + 1);
    // one per consumer stage
    localparam int CONS_CREDITS = 2;

    elem_op_e         mem_op [BUF_DEPTH];
    acc_t             mem_lanes [BUF_DEPTH][2*LANES];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [OCC_W-1:0] occ;
    logic [1:0]       cons_cred;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
        return (p == PTR_W'(BUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // a credit returning this cycle may be spent at once, keeps one beat per cycle
    assign pop      = (occ != '0) && ((cons_cred != '0) || rd.credit);
    assign rd.valid = pop;
    assign rd.op    = mem_op[rd_ptr];
    assign rd.lanes = mem_lanes[rd_ptr];
    assign wr.credit = pop;

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr.valid) begin
            mem_op[wr_ptr]    <= wr.op;
            mem_lanes[wr_ptr] <= wr.lanes;
        end
    end

    // pointers, occupancy and downstream credits
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occ       <= '0;
            cons_cred <= 2'(CONS_CREDITS);
        end else begin
            if (wr.valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            occ       <= occ + OCC_W'(wr.valid) - OCC_W'(pop);
            cons_cred <= cons_cred - 2'(pop) + 2'(rd.credit);
        end
    end

endmodule

`default_nettype wire

/* verilog/requant_stage.sv */
`default_nettype none

module requant_stage #(
    parameter int LANES = 8
) (
    input  logic                              clk,
    input  logic                              rst,
    elem_stream_if.rx                         link,
    input  elem_types_pkg::out_cfg_t          addsub_out_cfg_i,
    input  elem_types_pkg::out_cfg_t          mul_out_cfg_i,
    output logic                              out_valid_o,
    input  logic                              out_ready_i,
    output elem_types_pkg::lane_t [LANES-1:0] data_o
);
    import elem_types_pkg::*;
    import elem_arith_pkg::*;

    logic     out_fire;
    logic     s1_adv;
    logic     s1_valid;
    elem_op_e s1_op;
    acc_t     comb_val [LANES];
    acc_t     s1_val [LANES];
    out_cfg_t in_cfg;
    out_cfg_t s1_cfg;

    assign out_fire    = out_valid_o && out_ready_i;
    // output stage free or emptying this cycle
    assign s1_adv      = !out_valid_o || out_fire;
    assign link.credit = out_fire;

    assign in_cfg = (link.op == OP_MUL) ? mul_out_cfg_i : addsub_out_cfg_i;
    assign s1_cfg = (s1_op == OP_MUL) ? mul_out_cfg_i : addsub_out_cfg_i;

    // --------------------------------------------------
    // stage one, combine and output scaling
    // --------------------------------------------------
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            case (link.op)
                OP_ADD:  comb_val[l] = link.lanes[l] + link.lanes[LANES+l];
                OP_SUB:  comb_val[l] = link.lanes[l] - link.lanes[LANES+l];
                default: comb_val[l] = link.lanes[l];
            endcase
        end
    end

    // credits guarantee room in stage one whenever link.valid is high
    always_ff @(posedge clk) begin
        if (!rst) begin
            s1_valid <= 1'b0;
        end else if (link.valid) begin
            s1_valid <= 1'b1;
        end else if (s1_adv) begin
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (link.valid) begin
            s1_op <= link.op;
            for (int l = 0; l < LANES; l++) begin
                s1_val[l] <= mbqm(comb_val[l], in_cfg.output_multiplier, in_cfg.output_shift);
            end
        end
    end

    // --------------------------------------------------
    // stage two, output offset and clamp
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid_o <= 1'b0;
        end else if (s1_adv) begin
            out_valid_o <= s1_valid;
        end
    end

    // held while out_ready_i is low
    always_ff @(posedge clk) begin
        if (s1_adv && s1_valid) begin
            for (int l = 0; l < LANES; l++) begin
                data_o[l] <= clamp_to_lane(s1_val[l] + s1_cfg.output_offset,
                                           s1_cfg.act_min, s1_cfg.act_max);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/elementwise_quant.sv */
`default_nettype none

module elementwise_quant #(
    parameter int LANES     = 8,
    parameter int BUF_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    // input handshake
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  elem_types_pkg::elem_op_e op_i,
    input  logic [LANES*8-1:0]       data1_i,
    input  logic [LANES*8-1:0]       data2_i,
    // output handshake
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output logic [LANES*8-1:0]       data_o,
    // ADD and SUB config
    input  elem_types_pkg::acc_t     addsub_input1_offset_i,
    input  elem_types_pkg::acc_t     addsub_input2_offset_i,
    input  elem_types_pkg::shift_t   addsub_left_shift_i,
    input  elem_types_pkg::mult_t    addsub_input1_multiplier_i,
    input  elem_types_pkg::mult_t    addsub_input2_multiplier_i,
    input  elem_types_pkg::shift_t   addsub_input1_shift_i,
    input  elem_types_pkg::shift_t   addsub_input2_shift_i,
    input  elem_types_pkg::mult_t    addsub_output_multiplier_i,
    input  elem_types_pkg::shift_t   addsub_output_shift_i,
    input  elem_types_pkg::acc_t     addsub_output_offset_i,
    input  elem_types_pkg::lane_t    addsub_act_min_i,
    input  elem_types_pkg::lane_t    addsub_act_max_i,
    // MUL config
    input  elem_types_pkg::acc_t     mul_input1_offset_i,
    input  elem_types_pkg::acc_t     mul_input2_offset_i,
    input  elem_types_pkg::mult_t    mul_output_multiplier_i,
    input  elem_types_pkg::shift_t   mul_output_shift_i,
    input  elem_types_pkg::acc_t     mul_output_offset_i,
    input  elem_types_pkg::lane_t    mul_act_min_i,
    input  elem_types_pkg::lane_t    mul_act_max_i
);
    import elem_types_pkg::*;

    in_scale_cfg_t scale_cfg;
    mul_in_cfg_t   mul_in_cfg;
    out_cfg_t      addsub_out_cfg;
    out_cfg_t      mul_out_cfg;

    // --------------------------------------------------
    // config packing
    // --------------------------------------------------
    assign scale_cfg = '{
        input1_offset:     addsub_input1_offset_i,
        input2_offset:     addsub_input2_offset_i,
        left_shift:        addsub_left_shift_i,
        input1_multiplier: addsub_input1_multiplier_i,
        input2_multiplier: addsub_input2_multiplier_i,
        input1_shift:      addsub_input1_shift_i,
        input2_shift:      addsub_input2_shift_i
    };

    assign mul_in_cfg = '{
        input1_offset: mul_input1_offset_i,
        input2_offset: mul_input2_offset_i
    };

    assign addsub_out_cfg = '{
        output_multiplier: addsub_output_multiplier_i,
        output_shift:      addsub_output_shift_i,
        output_offset:     addsub_output_offset_i,
        act_min:           addsub_act_min_i,
        act_max:           addsub_act_max_i
    };

    assign mul_out_cfg = '{
        output_multiplier: mul_output_multiplier_i,
        output_shift:      mul_output_shift_i,
        output_offset:     mul_output_offset_i,
        act_min:           mul_act_min_i,
        act_max:           mul_act_max_i
    };

    // --------------------------------------------------
    // producer, buffer, consumer
    // --------------------------------------------------
    elem_stream_if #(.LANES(LANES)) prod_link ();
    elem_stream_if #(.LANES(LANES)) cons_link ();

    operand_stage #(
        .LANES     (LANES),
        .BUF_DEPTH (BUF_DEPTH)
    ) u_operand_stage (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .op_i        (op_i),
        .data1_i     (data1_i),
        .data2_i     (data2_i),
        .scale_cfg_i (scale_cfg),
        .mul_cfg_i   (mul_in_cfg),
        .link        (prod_link)
    );

    result_buffer #(
        .LANES     (LANES),
        .BUF_DEPTH (BUF_DEPTH)
    ) u_result_buffer (
        .clk (clk),
        .rst (rst),
        .wr  (prod_link),
        .rd  (cons_link)
    );

    requant_stage #(
        .LANES (LANES)
    ) u_requant_stage (
        .clk              (clk),
        .rst              (rst),
        .link             (cons_link),
        .addsub_out_cfg_i (addsub_out_cfg),
        .mul_out_cfg_i    (mul_out_cfg),
        .out_valid_o      (out_valid_o),
        .out_ready_i      (out_ready_i),
        .data_o           (data_o)
    );

endmodule

`default_nettype wire

/* tests/tb_elementwise_quant.sv */
`default_nettype none

module tb_elementwise_quant;
    timeunit 1ns;
    timeprecision 1ps;

    import elem_types_pkg::*;

    localparam int LANES       = 8;
    localparam int BUF_DEPTH   = 4;
    localparam int DIR_BEATS   = 120;
    localparam int BP_BEATS    = 20;
    localparam int MIX_BEATS   = 20;
    localparam int TOTAL_BEATS = 3 * DIR_BEATS + BP_BEATS + MIX_BEATS;
    // room for gaps and stalls on both handshakes
    localparam int MAX_CYCLES  = 10 * TOTAL_BEATS;

    logic               clk;
    logic               rst;
    logic               in_valid_i;
    logic               in_ready_o;
    elem_op_e           op_i;
    logic [LANES*8-1:0] data1_i;
    logic [LANES*8-1:0] data2_i;
    logic               out_valid_o;
    logic               out_ready_i;
    logic [LANES*8-1:0] data_o;

    acc_t   as_in1_off;
    acc_t   as_in2_off;
    shift_t as_left_shift;
    mult_t  as_in1_mult;
    mult_t  as_in2_mult;
    shift_t as_in1_shift;
    shift_t as_in2_shift;
    mult_t  as_out_mult;
    shift_t as_out_shift;
    acc_t   as_out_off;
    lane_t  as_act_min;
    lane_t  as_act_max;
    acc_t   mul_in1_off;
    acc_t   mul_in2_off;
    mult_t  mul_out_mult;
    shift_t mul_out_shift;
    acc_t   mul_out_off;
    lane_t  mul_act_min;
    lane_t  mul_act_max;

    logic [LANES*8-1:0] exp_q [$];
    logic [LANES*8-1:0] expected;
    int                 error_count;
    int                 check_count;
    int                 cycle_count;
    int                 ready_mode;

    elementwise_quant #(
        .LANES     (LANES),
        .BUF_DEPTH (BUF_DEPTH)
    ) UUT (
        .clk                        (clk),
        .rst                        (rst),
        .in_valid_i                 (in_valid_i),
        .in_ready_o                 (in_ready_o),
        .op_i                       (op_i),
        .data1_i                    (data1_i),
        .data2_i                    (data2_i),
        .out_valid_o                (out_valid_o),
        .out_ready_i                (out_ready_i),
        .data_o                     (data_o),
        .addsub_input1_offset_i     (as_in1_off),
        .addsub_input2_offset_i     (as_in2_off),
        .addsub_left_shift_i        (as_left_shift),
        .addsub_input1_multiplier_i (as_in1_mult),
        .addsub_input2_multiplier_i (as_in2_mult),
        .addsub_input1_shift_i      (as_in1_shift),
        .addsub_input2_shift_i      (as_in2_shift),
        .addsub_output_multiplier_i (as_out_mult),
        .addsub_output_shift_i      (as_out_shift),
        .addsub_output_offset_i     (as_out_off),
        .addsub_act_min_i           (as_act_min),
        .addsub_act_max_i           (as_act_max),
        .mul_input1_offset_i        (mul_in1_off),
        .mul_input2_offset_i        (mul_in2_off),
        .mul_output_multiplier_i    (mul_out_mult),
        .mul_output_shift_i         (mul_out_shift),
        .mul_output_offset_i        (mul_out_off),
        .mul_act_min_i              (mul_act_min),
        .mul_act_max_i              (mul_act_max)
    );

    // --------------------------------------------------
    // expected values from the fixed-point rules
    // --------------------------------------------------
    // divide by 2**e with ties away from zero
    function automatic longint round_shift_right(longint x, int e);
        longint half;
        longint div;
        if (e <= 0) begin
            return x;
        end
        half = longint'(1) <<< (e - 1);
        div  = longint'(1) <<< e;
        return (x >= 0) ? (x + half) / div : (x - half) / div;
    endfunction

    function automatic longint scale_fixed(longint x, longint m, int shift);
        longint xs;
        longint prod;
        longint high;
        xs = (shift > 0) ? longint'(int'(x <<< shift)) : x;
        if (xs == -64'sd2147483648 && m == -64'sd2147483648) begin
            high = 64'sd2147483647;
        end else begin
            prod = xs * m;
            if (prod >= 0) begin
                high = (prod + (64'sd1 <<< 30)) / (64'sd1 <<< 31);
            end else begin
                high = (prod + 64'sd1 - (64'sd1 <<< 30)) / (64'sd1 <<< 31);
            end
        end
        return round_shift_right(longint'(int'(high)), (shift > 0) ? 0 : -shift);
    endfunction

    function automatic logic [7:0] clamp_int8(longint v, longint lo, longint hi);
        if (v < lo) begin
            return 8'(lo);
        end
        if (v > hi) begin
            return 8'(hi);
        end
        return 8'(v);
    endfunction

    function automatic logic [LANES*8-1:0] expected_vector(elem_op_e op,
                                                           logic [LANES*8-1:0] d1,
                                                           logic [LANES*8-1:0] d2);
        logic [LANES*8-1:0] res;
        longint             a;
        longint             b;
        longint             sa;
        longint             sb;
        longint             v;
        for (int l = 0; l < LANES; l++) begin
            a = longint'($signed(d1[l*8 +: 8]));
            b = longint'($signed(d2[l*8 +: 8]));
            if (op == OP_MUL) begin
                v = longint'(int'((a + mul_in1_off) * (b + mul_in2_off)));
                v = scale_fixed(v, mul_out_mult, int'(mul_out_shift));
                v = longint'(int'(v + mul_out_off));
                res[l*8 +: 8] = clamp_int8(v, mul_act_min, mul_act_max);
            end else begin
                sa = longint'(int'((a + as_in1_off) <<< as_left_shift));
                sb = longint'(int'((b + as_in2_off) <<< as_left_shift));
                sa = scale_fixed(sa, as_in1_mult, int'(as_in1_shift));
                sb = scale_fixed(sb, as_in2_mult, int'(as_in2_shift));
                // SUB negates the scaled second operand
                v = (op == OP_SUB) ? longint'(int'(sa - sb)) : longint'(int'(sa + sb));
                v = scale_fixed(v, as_out_mult, int'(as_out_shift));
                v = longint'(int'(v + as_out_off));
                res[l*8 +: 8] = clamp_int8(v, as_act_min, as_act_max);
            end
        end
        return res;
    endfunction

    // --------------------------------------------------
    // clock, output ready, accept monitor and compare
    // --------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 0 always ready, 1 held low, 2 random
    always @(negedge clk) begin
        case (ready_mode)
            0:       out_ready_i = 1'b1;
            1:       out_ready_i = 1'b0;
            default: out_ready_i = ($urandom_range(3, 0) != 0);
        endcase
    end

    always @(posedge clk) begin
        if (rst && in_valid_i && in_ready_o) begin
            exp_q.push_back(expected_vector(op_i, data1_i, data2_i));
        end
    end

    always @(posedge clk) begin
        if (rst && out_valid_o && out_ready_i) begin
            check_count++;
            assert (exp_q.size() > 0) else begin
                error_count++;
                $display("output handshake with no beat outstanding");
            end
            if (exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                assert (data_o === expected) else begin
                    error_count++;
                    $display("FAILED data_o expected %h actual %h", expected, data_o);
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, results still missing", MAX_CYCLES);
        $display("checks %0d errors %0d", check_count, error_count + 1);
        $display("Regression failed");
        $finish;
    end

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------
    task automatic randomize_config();
        as_in1_off    = int'($urandom_range(255, 0)) - 128;
        as_in2_off    = int'($urandom_range(255, 0)) - 128;
        as_left_shift = 8'sd20;
        as_in1_mult   = mult_t'(32'h4000_0000 + $urandom_range(32'h3fff_ffff, 0));
        as_in2_mult   = mult_t'(32'h4000_0000 + $urandom_range(32'h3fff_ffff, 0));
        as_in1_shift  = shift_t'(-int'($urandom_range(3, 0)));
        as_in2_shift  = shift_t'(-int'($urandom_range(3, 0)));
        as_out_mult   = mult_t'(32'h4000_0000 + $urandom_range(32'h3fff_ffff, 0));
        as_out_shift  = -8'sd20;
        as_out_off    = int'($urandom_range(40, 0)) - 20;
        as_act_min    = -8'sd128;
        as_act_max    = 8'sd127;
        mul_in1_off   = int'($urandom_range(255, 0)) - 128;
        mul_in2_off   = int'($urandom_range(255, 0)) - 128;
        mul_out_mult  = mult_t'(32'h4000_0000 + $urandom_range(32'h3fff_ffff, 0));
        mul_out_shift = -8'sd9;
        mul_out_off   = int'($urandom_range(20, 0)) - 10;
        // narrow window so clamping is common
        mul_act_min   = -8'sd40;
        mul_act_max   = 8'sd50;
    endtask

    task automatic apply_beat(elem_op_e op);
        in_valid_i = 1'b1;
        op_i       = op;
        for (int l = 0; l < LANES; l++) begin
            data1_i[l*8 +: 8] = 8'($urandom);
            data2_i[l*8 +: 8] = 8'($urandom);
        end
    endtask

    // returns at the edge that took the beat
    task automatic wait_accept();
        do begin
            @(posedge clk);
        end while (!in_ready_o);
    endtask

    task automatic send_beat(elem_op_e op, int max_gap);
        int gap;
        gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
        @(negedge clk);
        repeat (gap) begin
            in_valid_i = 1'b0;
            @(negedge clk);
        end
        apply_beat(op);
        wait_accept();
    endtask

    task automatic drain();
        @(negedge clk);
        in_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic set_ready_mode(int mode);
        @(posedge clk);
        ready_mode = mode;
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(32'hb91c));
        rst          = 1'b0;
        in_valid_i   = 1'b0;
        op_i         = OP_ADD;
        data1_i      = '0;
        data2_i      = '0;
        out_ready_i  = 1'b1;
        ready_mode   = 0;
        error_count  = 0;
        check_count  = 0;
        randomize_config();

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_count++;
        assert (in_ready_o === 1'b1) else begin
            error_count++;
            $display("FAILED in_ready_o expected %h actual %h", 1'b1, in_ready_o);
        end
        check_count++;
        assert (out_valid_o === 1'b0) else begin
            error_count++;
            $display("FAILED out_valid_o expected %h actual %h", 1'b0, out_valid_o);
        end

        // one op per phase with beats back to back
        repeat (DIR_BEATS) send_beat(OP_ADD, 0);
        drain();
        repeat (DIR_BEATS) send_beat(OP_SUB, 0);
        drain();
        repeat (DIR_BEATS) send_beat(OP_MUL, 0);
        drain();

        // fill the pipeline with the output stalled
        set_ready_mode(1);
        repeat (BUF_DEPTH + 2) send_beat(elem_op_e'($urandom_range(2, 0)), 0);
        @(negedge clk);
        apply_beat(elem_op_e'($urandom_range(2, 0)));
        repeat (12) begin
            @(posedge clk);
            check_count++;
            assert (!in_ready_o) else begin
                error_count++;
                $display("more than %0d beats accepted while the output was stalled",
                         BUF_DEPTH + 2);
            end
        end
        set_ready_mode(2);
        wait_accept();
        repeat (BP_BEATS) send_beat(elem_op_e'($urandom_range(2, 0)), 0);
        drain();

        // random op per beat with gaps on both sides
        repeat (MIX_BEATS) send_beat(elem_op_e'($urandom_range(2, 0)), 3);
        drain();

        // no extra result may be pending once every beat is back
        check_count++;
        assert (out_valid_o === 1'b0) else begin
            error_count++;
            $display("FAILED out_valid_o expected %h actual %h", 1'b0, out_valid_o);
        end

        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* elementwise_quant.f */
verilog/elem_types_pkg.sv
verilog/elem_arith_pkg.sv
verilog/elem_stream_if.sv
verilog/operand_stage.sv
verilog/result_buffer.sv
verilog/requant_stage.sv
verilog/elementwise_quant.sv
tests/tb_elementwise_quant.sv
